// ==== common/lift_defs.svh ====
`ifndef LIFT_DEFS_SVH
`define LIFT_DEFS_SVH

// Memory side widths
`define LIFT_ADDR_W          9    // Block address, 0 to 511
`define LIFT_PSEL_W          3    // Processor select
`define LIFT_MSEL_W          4    // Memory select inside one processor

// Lift unit side
`define LIFT_BUF_ADDR_W      6    // Lift I/O buffer address
`define LIFT_INSTR_W         8    // Instruction word

// Last processor index of a walk
`define LIFT_LAST_PROC_A     5    // Six processors
`define LIFT_LAST_PROC_B     6    // Seven processors

// Full polynomial is 512 blocks
`define LIFT_DEFAULT_BLOCKS  512

`endif

// ==== common/lift_pkg.sv ====
`default_nettype none

`include "lift_defs.svh"

package lift_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Controller states
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		st_init,        // After reset, lift unit held
		st_rd_addr,     // Present block address
		st_rd_fetch,    // Memory read latency
		st_rd_load,     // Word into lift input buffer
		st_lift_setup,  // Release lift unit, rewind buffer address
		st_lift_start,  // One cycle start strobe
		st_lift_wait,   // Wait for lift_done
		st_wr_addr,     // Present write address and buffer address
		st_wr_store,    // Word back into processor memory
		st_finish       // All blocks done, sticks here
	} lift_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Decoded instruction
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		op_large_crt,        // 13 words in, 6 out
		op_small_crt,        // Instruction 5, 6 in, 7 out
		op_large_crt_reduce  // Instruction 7, 13 in, 2 x 6 out
	} lift_op_e;

	// Vector types from the widths in the defs header
	typedef logic [`LIFT_ADDR_W-1:0]     addr_t;
	typedef logic [`LIFT_PSEL_W-1:0]     psel_t;
	typedef logic [`LIFT_MSEL_W-1:0]     msel_t;
	typedef logic [`LIFT_BUF_ADDR_W-1:0] buf_addr_t;

endpackage

`default_nettype wire

// ==== lift_ctrl/lift_sequencer.sv ====
`default_nettype none

module lift_sequencer import lift_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        load_over,      // Last word of read walk loaded
	input  wire        store_over,     // Write-back of block complete
	input  wire        last_block,     // ... and it was the final block
	input  wire        lift_done,      // Lift unit finished
	output logic       read_phase,
	output logic       write_phase,
	output logic       lift_buf_we,    // Load strobe
	output logic       bram_we,        // Store strobe
	output buf_addr_t  lift_buf_addr,
	output logic       lift_start,
	output logic       lift_hold,      // Lift unit in reset
	output logic       done
);

	lift_state_e state;
	lift_state_e next_state;

	logic buf_addr_clr;  // Rewind lift buffer address

	////////////////////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_init;
		else
			state <= next_state;
	end

	// Next state
	always_comb begin
		next_state = state;
		case (state)
			st_init:       next_state = st_rd_addr;
			st_rd_addr:    next_state = st_rd_fetch;
			st_rd_fetch:   next_state = st_rd_load;
			st_rd_load: begin
				if (load_over)
					next_state = st_lift_setup;   // Input buffer full
				else
					next_state = st_rd_fetch;     // Next processor
			end
			st_lift_setup: next_state = st_lift_start;
			st_lift_start: next_state = st_lift_wait;
			st_lift_wait: begin
				if (lift_done)
					next_state = st_wr_addr;
			end
			st_wr_addr:    next_state = st_wr_store;
			st_wr_store: begin
				if (last_block)
					next_state = st_finish;
				else if (store_over)
					next_state = st_rd_addr;      // Next block
				else
					next_state = st_wr_addr;
			end
			st_finish:     next_state = st_finish;  // Only reset leaves
			default:       next_state = st_init;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State decoded outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		read_phase   = 1'b0;
		write_phase  = 1'b0;
		lift_buf_we  = 1'b0;
		bram_we      = 1'b0;
		lift_start   = 1'b0;
		lift_hold    = 1'b0;
		done         = 1'b0;
		buf_addr_clr = 1'b0;
		case (state)
			st_init: begin
				lift_hold    = 1'b1;
				buf_addr_clr = 1'b1;
			end
			st_rd_addr: begin
				read_phase   = 1'b1;
				lift_hold    = 1'b1;
				buf_addr_clr = 1'b1;  // Loads start at buffer word 0
			end
			st_rd_fetch: begin
				read_phase = 1'b1;
				lift_hold  = 1'b1;
			end
			st_rd_load: begin
				read_phase  = 1'b1;
				lift_hold   = 1'b1;
				lift_buf_we = 1'b1;
			end
			st_lift_setup: buf_addr_clr = 1'b1;  // Results drain from word 0
			st_lift_start: lift_start   = 1'b1;
			st_lift_wait: begin
				// Lift unit runs, nothing driven
			end
			st_wr_addr: begin
				write_phase = 1'b1;
				lift_hold   = 1'b1;
			end
			st_wr_store: begin
				write_phase = 1'b1;
				lift_hold   = 1'b1;
				bram_we     = 1'b1;
			end
			st_finish: done = 1'b1;
			default: begin
				lift_hold    = 1'b1;
				buf_addr_clr = 1'b1;
			end
		endcase
	end

	// Lift buffer address, one word per load or store strobe
	always_ff @(posedge clk) begin
		if (rst || buf_addr_clr)
			lift_buf_addr <= '0;
		else if (lift_buf_we || bram_we)
			lift_buf_addr <= lift_buf_addr + 1'b1;
	end

endmodule

`default_nettype wire

// ==== lift_ctrl/bram_walker.sv ====
`default_nettype none

`include "lift_defs.svh"

module bram_walker import lift_pkg::*; #(
	parameter int block_count = `LIFT_DEFAULT_BLOCKS
) (
	input  wire                      clk,
	input  wire                      rst,
	input  wire [`LIFT_INSTR_W-1:0]  instruction,
	input  wire msel_t               mem_r0,       // First read pass
	input  wire msel_t               mem_r1,       // Second read pass, large CRT
	input  wire msel_t               mem_w0,       // First write pass
	input  wire msel_t               mem_w1,       // Second write pass, reduction
	input  wire                      read_phase,
	input  wire                      write_phase,
	input  wire                      lift_buf_we,  // Load strobe
	input  wire                      bram_we,      // Store strobe
	output psel_t                    processor_sel,
	output msel_t                    memory_sel,
	output addr_t                    bram_address,
	output logic                     load_over,
	output logic                     store_over,
	output logic                     last_block
);

	localparam logic [`LIFT_INSTR_W-1:0] instr_small  = 5;
	localparam logic [`LIFT_INSTR_W-1:0] instr_reduce = 7;
	localparam psel_t last_a = psel_t'(`LIFT_LAST_PROC_A);  // Six processors
	localparam psel_t last_b = psel_t'(`LIFT_LAST_PROC_B);  // Seven processors
	localparam addr_t last_addr = addr_t'(block_count - 1);

	lift_op_e op;
	logic     rd_second;   // Read walk in second pass, large CRT
	logic     wr_second;   // Write walk in second pass, reduction
	psel_t    rd_last;     // Last processor of current read pass
	psel_t    wr_last;     // Last processor of current write pass
	logic     rd_strobe;
	logic     wr_strobe;
	addr_t    rd_addr;
	addr_t    wr_addr;

	// Opcode decode
	always_comb begin
		case (instruction)
			instr_small:  op = op_small_crt;
			instr_reduce: op = op_large_crt_reduce;
			default:      op = op_large_crt;  // Any other value is large CRT
		endcase
	end

	assign rd_strobe = lift_buf_we && read_phase;
	assign wr_strobe = bram_we && write_phase;

	////////////////////////////////////////////////////////////////////////////
	// Walk limits and completion
	////////////////////////////////////////////////////////////////////////////

	// Large CRT reads 0..5 then 0..6, small CRT only 0..5
	assign rd_last = (op != op_small_crt && rd_second) ? last_b : last_a;
	// Small CRT writes seven words, the others six per pass
	assign wr_last = (op == op_small_crt) ? last_b : last_a;

	assign load_over  = rd_strobe && processor_sel == rd_last &&
	                    (op == op_small_crt || rd_second);
	assign store_over = wr_strobe && processor_sel == wr_last &&
	                    (op != op_large_crt_reduce || wr_second);
	assign last_block = store_over && wr_addr == last_addr;

	// Processor walk
	always_ff @(posedge clk) begin
		if (rst)
			processor_sel <= '0;
		else if (rd_strobe)
			processor_sel <= (processor_sel == rd_last) ? psel_t'(0) : processor_sel + 1'b1;
		else if (wr_strobe)
			processor_sel <= (processor_sel == wr_last) ? psel_t'(0) : processor_sel + 1'b1;
	end

	// Pass flags
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_second <= 1'b0;
			wr_second <= 1'b0;
		end else begin
			if (load_over)
				rd_second <= 1'b0;
			else if (rd_strobe && op != op_small_crt && processor_sel == last_a)
				rd_second <= 1'b1;      // Switch to mem_r1
			if (store_over)
				wr_second <= 1'b0;
			else if (wr_strobe && op == op_large_crt_reduce && processor_sel == last_a)
				wr_second <= 1'b1;      // Switch to mem_w1
		end
	end

	// Block address counters
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_addr <= '0;
			wr_addr <= '0;
		end else begin
			if (load_over)
				rd_addr <= rd_addr + 1'b1;
			if (store_over)
				wr_addr <= wr_addr + 1'b1;
		end
	end

	assign bram_address = read_phase ? rd_addr : wr_addr;

	// Memory select per phase and pass
	always_comb begin
		if (read_phase)
			memory_sel = rd_second ? mem_r1 : mem_r0;
		else
			memory_sel = wr_second ? mem_w1 : mem_w0;
	end

endmodule

`default_nettype wire

// ==== hdl/lift_control.sv ====
`default_nettype none

`include "lift_defs.svh"

module lift_control import lift_pkg::*; #(
	parameter int block_count = `LIFT_DEFAULT_BLOCKS
) (
	input  wire                      clk,
	input  wire                      rst,
	input  wire [`LIFT_INSTR_W-1:0]  instruction,
	input  wire msel_t               mem_r0,
	input  wire msel_t               mem_r1,
	input  wire msel_t               mem_w0,
	input  wire msel_t               mem_w1,
	input  wire                      lift_done,
	output psel_t                    processor_sel,
	output msel_t                    memory_sel,
	output addr_t                    bram_address,
	output logic                     bram_we,
	output buf_addr_t                lift_buf_addr,
	output logic                     lift_buf_we,
	output logic                     lift_start,
	output logic                     lift_hold,
	output logic                     done
);

	// Sequencer to walker
	logic read_phase;
	logic write_phase;
	// Walker to sequencer
	logic load_over;
	logic store_over;
	logic last_block;

	////////////////////////////////////////////////////////////////////////////
	// Phase sequencing and lift unit control
	////////////////////////////////////////////////////////////////////////////

	lift_sequencer lift_sequencer_i (
		.clk           (clk),
		.rst           (rst),
		.load_over     (load_over),
		.store_over    (store_over),
		.last_block    (last_block),
		.lift_done     (lift_done),
		.read_phase    (read_phase),
		.write_phase   (write_phase),
		.lift_buf_we   (lift_buf_we),
		.bram_we       (bram_we),
		.lift_buf_addr (lift_buf_addr),
		.lift_start    (lift_start),
		.lift_hold     (lift_hold),
		.done          (done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Processor memory addressing
	////////////////////////////////////////////////////////////////////////////

	bram_walker #(
		.block_count (block_count)
	) bram_walker_i (
		.clk           (clk),
		.rst           (rst),
		.instruction   (instruction),
		.mem_r0        (mem_r0),
		.mem_r1        (mem_r1),
		.mem_w0        (mem_w0),
		.mem_w1        (mem_w1),
		.read_phase    (read_phase),
		.write_phase   (write_phase),
		.lift_buf_we   (lift_buf_we),
		.bram_we       (bram_we),
		.processor_sel (processor_sel),
		.memory_sel    (memory_sel),
		.bram_address  (bram_address),
		.load_over     (load_over),
		.store_over    (store_over),
		.last_block    (last_block)
	);

endmodule

`default_nettype wire

// ==== tests/lift_control_asserts.sv ====
`default_nettype none

`include "lift_defs.svh"

module lift_control_asserts (
	input wire                     clk,
	input wire                     rst,
	input wire                     lift_start,
	input wire                     lift_buf_we,
	input wire                     bram_we,
	input wire                     done,
	input wire [`LIFT_PSEL_W-1:0]  processor_sel
);

	// Start strobe is a single cycle
	start_one_cycle: assert property (@(posedge clk) disable iff (rst)
		lift_start |=> !lift_start)
		else $error("lift_start held for more than one cycle");

	// Load and store never share a cycle
	strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(lift_buf_we && bram_we))
		else $error("lift_buf_we and bram_we high together");

	done_sticks: assert property (@(posedge clk) disable iff (rst)
		done |=> done)
		else $error("done dropped without reset");

	// Seven processors at most
	psel_range: assert property (@(posedge clk) disable iff (rst)
		processor_sel <= `LIFT_LAST_PROC_B)
		else $error("processor_sel above last processor");

endmodule

bind lift_control lift_control_asserts lift_control_asserts_i (.*);

`default_nettype wire

// ==== tests/lift_control_tb.sv ====
`default_nettype none

`include "lift_defs.svh"

module lift_control_tb;

	localparam int blocks        = 4;
	localparam int period        = 4;
	localparam int block_cycles  = 64;  // Reduction block stays under 60 plus latency
	localparam int settle_cycles = 32;  // Reset, init and done hold per test

	logic                      clk = 1'b0;
	logic                      rst;
	logic [`LIFT_INSTR_W-1:0]  instruction;
	logic [`LIFT_MSEL_W-1:0]   mem_r0;
	logic [`LIFT_MSEL_W-1:0]   mem_r1;
	logic [`LIFT_MSEL_W-1:0]   mem_w0;
	logic [`LIFT_MSEL_W-1:0]   mem_w1;
	logic                      lift_done;
	wire [`LIFT_PSEL_W-1:0]    processor_sel;
	wire [`LIFT_MSEL_W-1:0]    memory_sel;
	wire [`LIFT_ADDR_W-1:0]    bram_address;
	wire [`LIFT_BUF_ADDR_W-1:0] lift_buf_addr;
	wire                       bram_we;
	wire                       lift_buf_we;
	wire                       lift_start;
	wire                       lift_hold;
	wire                       done;

	logic [7:0]  instr_q[$];   // Test table from the stimulus file
	logic [15:0] sel_q[$];     // r0 r1 w0 w1 packed
	int          lat_q[$];
	int          rd_psel[$];   // Expected read walk
	int          rd_msel[$];
	int          wr_psel[$];   // Expected write walk
	int          wr_msel[$];

	int load_idx, store_idx, block_idx, start_count;
	int errors = 0;
	int cur_test = 0;
	int max_lat = 0;
	int time_limit;
	int lift_count;
	bit lift_pending, answered, done_seen;
	bit active = 1'b0;
	bit tests_loaded = 1'b0;

	lift_control #(
		.block_count (blocks)
	) lift_control_i (.*);

	always #(period / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("Error: %s is %h, expected %h (test %0d, block %0d)",
			         name, actual, expected, cur_test, block_idx);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Test %0d block %0d: %s", cur_test, block_idx, what);
	endtask

	// One pass over processors 0..last on one memory
	task automatic add_walk(input int last, input int sel, input bit write);
		for (int p = 0; p <= last; p++) begin
			if (write) begin
				wr_psel.push_back(p);
				wr_msel.push_back(sel);
			end else begin
				rd_psel.push_back(p);
				rd_msel.push_back(sel);
			end
		end
	endtask

	task automatic run_test(input int t);
		cur_test = t;
		@(posedge clk);
		#1;
		active = 1'b0;
		rst    = 1'b1;
		instruction = instr_q[t];
		{mem_r0, mem_r1, mem_w0, mem_w1} = sel_q[t];
		rd_psel.delete();
		rd_msel.delete();
		wr_psel.delete();
		wr_msel.delete();
		add_walk(`LIFT_LAST_PROC_A, mem_r0, 1'b0);
		if (instruction == 5) begin
			add_walk(`LIFT_LAST_PROC_B, mem_w0, 1'b1);  // Small CRT writes seven
		end else begin
			add_walk(`LIFT_LAST_PROC_B, mem_r1, 1'b0);
			add_walk(`LIFT_LAST_PROC_A, mem_w0, 1'b1);
			if (instruction == 7)
				add_walk(`LIFT_LAST_PROC_A, mem_w1, 1'b1);  // Reduction pass
		end
		load_idx     = 0;
		store_idx    = 0;
		block_idx    = 0;
		start_count  = 0;
		answered     = 1'b0;
		done_seen    = 1'b0;
		lift_pending = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value("lift_hold", lift_hold, 1);       // Reset values
		check_value("strobes", {lift_buf_we, bram_we, lift_start, done}, 0);
		@(posedge clk);
		#1;
		rst    = 1'b0;
		active = 1'b1;
		wait (done_seen);
		repeat (8) @(negedge clk);  // Done must hold with no strobes
		check_value("blocks", block_idx, blocks);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Lift unit model and response monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		#1;
		lift_done = 1'b0;
		if (lift_pending) begin
			if (lift_count == 0) begin
				lift_done    = 1'b1;  // One cycle pulse
				lift_pending = 1'b0;
			end else begin
				lift_count--;
			end
		end
	end

	always @(negedge clk) begin
		if (active) begin
			if (done_seen && !done)
				report_failure("done fell before reset");
			if (done_seen && (lift_buf_we || bram_we || lift_start))
				report_failure("strobe seen after done");
			if (done && !done_seen) begin
				done_seen = 1'b1;
				check_value("blocks at done", block_idx, blocks);
			end
			if (lift_start) begin
				if (load_idx != rd_psel.size() || store_idx != 0)
					report_failure("lift_start not between last load and first store");
				check_value("lift_hold", lift_hold, 0);  // Lift unit released
				start_count++;
				if (start_count > 1)
					report_failure("more than one lift_start in a block");
				lift_pending = 1'b1;
				lift_count   = lat_q[cur_test];
			end
			if (lift_done && start_count == 1)
				answered = 1'b1;
			if (lift_buf_we) begin
				if (store_idx != 0)
					report_failure("load during write-back");
				if (load_idx >= rd_psel.size()) begin
					report_failure("more loads than the read walk holds");
				end else begin
					check_value("processor_sel", processor_sel, rd_psel[load_idx]);
					check_value("memory_sel", memory_sel, rd_msel[load_idx]);
				end
				check_value("bram_address", bram_address, block_idx);
				check_value("lift_buf_addr", lift_buf_addr, load_idx);
				check_value("lift_hold", lift_hold, 1);
				load_idx++;
			end
			if (bram_we) begin
				if (load_idx != rd_psel.size() || !answered)
					report_failure("store before all loads and lift_done");
				check_value("processor_sel", processor_sel, wr_psel[store_idx]);
				check_value("memory_sel", memory_sel, wr_msel[store_idx]);
				check_value("bram_address", bram_address, block_idx);
				check_value("lift_buf_addr", lift_buf_addr, store_idx);
				check_value("lift_hold", lift_hold, 1);
				store_idx++;
				if (store_idx == wr_psel.size()) begin  // Block complete
					block_idx++;
					load_idx    = 0;
					store_idx   = 0;
					start_count = 0;
					answered    = 1'b0;
				end
			end
		end
	end

	// Watchdog scaled by test count and longest latency
	initial begin
		wait (tests_loaded);
		#(time_limit);
		$display("Timeout: test %0d hung in block %0d", cur_test, block_idx);
		$display("Errors: %0d", errors + 1);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int         fd;
		int         n;
		int         lat;
		string      line;
		logic [7:0] instr;
		logic [3:0] r0, r1, w0, w1;
		rst         = 1'b1;
		instruction = '0;
		mem_r0      = '0;
		mem_r1      = '0;
		mem_w0      = '0;
		mem_w1      = '0;
		lift_done   = 1'b0;
		void'($urandom(32'h299b));
		fd = $fopen("tests/lift_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tests/lift_stimulus.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && $sscanf(line, "%h %h %h %h %h %h",
				                     instr, r0, r1, w0, w1, lat) == 6) begin
					instr_q.push_back(instr);
					sel_q.push_back({r0, r1, w0, w1});
					lat_q.push_back(lat);
					if (lat > max_lat)
						max_lat = lat;
				end
			end
			$fclose(fd);
			do
				instr = 8'($urandom);  // Extra large CRT with any code but 5 and 7
			while (instr == 5 || instr == 7);
			instr_q.push_back(instr);
			sel_q.push_back(16'($urandom));
			lat_q.push_back($urandom % 7);
			if (lat_q[$] > max_lat)
				max_lat = lat_q[$];
			time_limit = instr_q.size() * (blocks * (block_cycles + max_lat) + settle_cycles)
			             * period;
			tests_loaded = 1'b1;
			foreach (instr_q[t])
				run_test(t);
		end
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/lift_stimulus.txt ====
# instruction mem_r0 mem_r1 mem_w0 mem_w1 lift_latency, all hex
# instruction 05 small CRT, 07 large CRT with reduction, any other large CRT
05 1 2 3 4 0
05 a b c d 6
05 0 f 8 1 3
00 1 2 3 4 1
01 3 5 7 9 4
06 e d c b 2
ff 2 4 6 8 5
07 1 2 3 4 0
07 9 8 7 6 6
07 f 0 5 a 2

// ==== compile.f ====
+incdir+common
common/lift_pkg.sv
lift_ctrl/lift_sequencer.sv
lift_ctrl/bram_walker.sv
hdl/lift_control.sv
tests/lift_control_asserts.sv
tests/lift_control_tb.sv
